/* soc_misc_pkg.sv */
/*
 * Shared types and constants for the misc register bus slave.
 * Request/response bundles, address decode enums and fixed register values
 * are defined here once and imported by each module that needs them.
 */

package soc_misc_pkg;

	// ------------------------------------------------------------------------
	// bus bundles
	// ------------------------------------------------------------------------

	// one request as queued between the port and the register block
	typedef struct packed {
		logic        write;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  strb;
	} bus_req_t;

	// read data returned through the response port
	typedef struct packed {
		logic [31:0] rdata;
	} bus_rsp_t;

	// ------------------------------------------------------------------------
	// address decode
	// ------------------------------------------------------------------------

	// only the misc value of address bits 31:28 is mapped
	typedef enum logic [3:0] {
		REGION_MISC = 4'h2
	} region_e;

	// register index from address bits 6:2
	typedef enum logic [4:0] {
		REG_LED       = 5'd0,
		REG_BTN       = 5'd1,
		REG_SOC_VER   = 5'd2,
		REG_FLASH_SEL = 5'd13,
		REG_GENIO_IN  = 5'd17,
		REG_GENIO_OUT = 5'd18,
		REG_GENIO_OE  = 5'd19,
		REG_GENIO_W2S = 5'd20,
		REG_GENIO_W2C = 5'd21
	} misc_reg_e;

	// pin widths
	localparam int LED_W   = 16;
	localparam int BTN_W   = 8;
	localparam int GENIO_W = 30;

	localparam logic [31:0] SOC_VERSION    = 32'h0000_8000;
	localparam logic [31:0] BUS_ERROR_DATA = 32'hDEAD_BEEF;

	// upper 24 bits of a flash-select write that request reconfiguration
	localparam logic [23:0] RELOAD_KEY = 24'hD0F1A5;

	// flash-select count starts here and pulses the clock at counts 5..3
	localparam logic [2:0] FSEL_DELAY_START = 3'd7;

endpackage

/* fsel_sequencer.sv */
/*
 * Flash-select sequencing. After a select write the flash mux clock is
 * pulsed after a short delay, and a keyed write then pulls PROGRAMN low.
 */

`timescale 1ns/100ps

module fsel_sequencer (
	input  logic clk48m,
	input  logic rst,
	input  logic strobe_i,
	input  logic reload_i,
	output logic fsel_c_o,
	output logic programn_o
);
	import soc_misc_pkg::*;

	logic [2:0] delay_q;
	logic       reload_pend;

	// ------------------------------------------------------------------------
	// delay counter
	// ------------------------------------------------------------------------

	// give the select flop time to settle before reconfiguration
	always_ff @(posedge clk48m) begin
		if (rst) begin
			delay_q     <= '0;
			reload_pend <= 1'b0;
			programn_o  <= 1'b1;
		end else begin
			if (strobe_i && reload_i) begin
				reload_pend <= 1'b1;
			end
			if (strobe_i) begin
				delay_q <= FSEL_DELAY_START;
			end else if (delay_q != '0) begin
				delay_q <= delay_q - 1'b1;
				// last step of the count, stays low until reset
				if (delay_q == 3'd1 && reload_pend) begin
					programn_o <= 1'b0;
				end
			end
		end
	end

	// clock the select value into the mux at counts 5, 4 and 3
	assign fsel_c_o = (delay_q == 3'd5) || (delay_q == 3'd4) || (delay_q == 3'd3);

endmodule

/* bus_port.sv */
/*
 * Four-phase req/ack front end. A held request is captured, pushed into
 * the request FIFO once there is room, then acknowledged until req drops.
 */

`timescale 1ns/100ps

module bus_port (
	input  logic                    clk48m,
	input  logic                    rst,
	input  logic                    req_i,
	input  soc_misc_pkg::bus_req_t  req_data_i,
	output logic                    ack_o,
	input  logic                    full_i,
	output logic                    push_o,
	output soc_misc_pkg::bus_req_t  push_data_o
);
	import soc_misc_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_PUSH,
		ST_ACK
	} port_state_e;

	port_state_e state_q;
	bus_req_t    hold_q;

	// control path
	always_ff @(posedge clk48m) begin
		if (rst) begin
			state_q <= ST_IDLE;
			push_o  <= 1'b0;
			ack_o   <= 1'b0;
		end else begin
			push_o <= 1'b0;
			ack_o  <= (state_q == ST_ACK) && req_i;
			case (state_q)
				ST_IDLE: begin
					if (req_i) begin
						state_q <= ST_PUSH;
					end
				end
				ST_PUSH: begin
					// wait here while the queue is full
					if (!full_i) begin
						push_o  <= 1'b1;
						state_q <= ST_ACK;
					end
				end
				ST_ACK: begin
					if (!req_i) begin
						state_q <= ST_IDLE;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// request payload, master keeps it stable while req is high
	always_ff @(posedge clk48m) begin
		if (state_q == ST_IDLE && req_i) begin
			hold_q <= req_data_i;
		end
	end

	assign push_data_o = hold_q;

	// push is registered, so room must still exist one cycle after the check
	a_push_not_full: assert property (@(posedge clk48m) disable iff (rst)
		push_o |-> !full_i)
		else $error("push into full request queue");

endmodule

/* req_fifo.sv */
/*
 * Request queue between the bus port and the register block.
 * Circular buffer with a head that is visible one cycle after a push.
 */

`timescale 1ns/100ps

module req_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                    clk48m,
	input  logic                    rst,
	input  logic                    push_i,
	input  soc_misc_pkg::bus_req_t  push_data_i,
	output logic                    full_o,
	input  logic                    pop_i,
	output logic                    empty_o,
	output soc_misc_pkg::bus_req_t  head_o
);
	import soc_misc_pkg::*;

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = PTR_W + 1;

	bus_req_t             mem [FIFO_DEPTH];
	logic [PTR_W-1:0]     wr_ptr;
	logic [PTR_W-1:0]     rd_ptr;
	logic [CNT_W-1:0]     count;

	// ------------------------------------------------------------------------
	// pointers and fill level
	// ------------------------------------------------------------------------

	always_ff @(posedge clk48m) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_i) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop_i) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push_i, pop_i})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// storage, depth is a power of two so the pointers wrap by themselves
	always_ff @(posedge clk48m) begin
		if (push_i) begin
			mem[wr_ptr] <= push_data_i;
		end
	end

	assign head_o  = mem[rd_ptr];
	assign empty_o = (count == '0);
	assign full_o  = (count == CNT_W'(FIFO_DEPTH));

	a_no_pop_empty: assert property (@(posedge clk48m) disable iff (rst)
		pop_i |-> !empty_o)
		else $error("pop from empty request queue");

	a_no_push_full: assert property (@(posedge clk48m) disable iff (rst)
		push_i |-> !full_o)
		else $error("push into full request queue");

endmodule

/* misc_regs.sv */
/*
 * Misc register block. Executes queued requests in order, holds the LED,
 * general I/O and flash-select registers, and returns read data through a
 * valid/ready port that stalls execution while a response is not taken.
 */

`timescale 1ns/100ps

module misc_regs (
	input  logic                                 clk48m,
	input  logic                                 rst,
	input  logic                                 empty_i,
	input  soc_misc_pkg::bus_req_t               head_i,
	output logic                                 pop_o,
	output logic                                 rsp_valid_o,
	output soc_misc_pkg::bus_rsp_t               rsp_data_o,
	input  logic                                 rsp_ready_i,
	input  logic [soc_misc_pkg::BTN_W-1:0]       btn_i,
	input  logic [soc_misc_pkg::GENIO_W-1:0]     genio_in_i,
	output logic [soc_misc_pkg::LED_W-1:0]       led_o,
	output logic [soc_misc_pkg::GENIO_W-1:0]     genio_out_o,
	output logic [soc_misc_pkg::GENIO_W-1:0]     genio_oe_o,
	output logic                                 fsel_d_o,
	output logic                                 fsel_c_o,
	output logic                                 programn_o,
	output logic                                 bus_error_o
);
	import soc_misc_pkg::*;

	region_e          region;
	misc_reg_e        reg_idx;
	logic             in_misc;
	logic             wr_en;
	logic [BTN_W-1:0] btn_n;
	logic [31:0]      rd_data;
	logic             fsel_strobe;
	logic             fsel_reload;

	// ------------------------------------------------------------------------
	// decode of the queue head
	// ------------------------------------------------------------------------

	assign region  = region_e'(head_i.addr[31:28]);
	assign reg_idx = misc_reg_e'(head_i.addr[6:2]);
	assign in_misc = (region == REGION_MISC);

	// execute only when no response is left waiting
	assign pop_o = !empty_i && (!rsp_valid_o || rsp_ready_i);
	assign wr_en = pop_o && head_i.write && in_misc && head_i.strb[0];

	// buttons are active low on the board
	assign btn_n = ~btn_i;

	always_comb begin
		rd_data = '0;
		if (!in_misc) begin
			rd_data = BUS_ERROR_DATA;
		end else begin
			case (reg_idx)
				REG_LED:       rd_data = 32'(led_o);
				REG_BTN:       rd_data = 32'(btn_n);
				REG_SOC_VER:   rd_data = SOC_VERSION;
				REG_FLASH_SEL: rd_data = 32'(fsel_d_o);
				REG_GENIO_IN:  rd_data = 32'(genio_in_i);
				REG_GENIO_OUT: rd_data = 32'(genio_out_o);
				REG_GENIO_OE:  rd_data = 32'(genio_oe_o);
				default:       rd_data = '0;
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// register writes
	// ------------------------------------------------------------------------

	always_ff @(posedge clk48m) begin
		if (rst) begin
			led_o       <= '0;
			genio_out_o <= '0;
			genio_oe_o  <= '0;
			fsel_d_o    <= 1'b0;
			fsel_strobe <= 1'b0;
			fsel_reload <= 1'b0;
		end else begin
			fsel_strobe <= 1'b0;
			fsel_reload <= 1'b0;
			if (wr_en) begin
				case (reg_idx)
					REG_LED:       led_o <= head_i.wdata[LED_W-1:0];
					REG_GENIO_OUT: genio_out_o <= head_i.wdata[GENIO_W-1:0];
					REG_GENIO_OE:  genio_oe_o <= head_i.wdata[GENIO_W-1:0];
					REG_GENIO_W2S: genio_out_o <= genio_out_o | head_i.wdata[GENIO_W-1:0];
					REG_GENIO_W2C: genio_out_o <= genio_out_o & ~head_i.wdata[GENIO_W-1:0];
					REG_FLASH_SEL: begin
						fsel_d_o    <= head_i.wdata[0];
						fsel_strobe <= 1'b1;
						fsel_reload <= (head_i.wdata[31:8] == RELOAD_KEY);
					end
					default: ;
				endcase
			end
		end
	end

	// ------------------------------------------------------------------------
	// response port and bus error
	// ------------------------------------------------------------------------

	always_ff @(posedge clk48m) begin
		if (rst) begin
			rsp_valid_o <= 1'b0;
			bus_error_o <= 1'b0;
		end else begin
			bus_error_o <= pop_o && !in_misc;
			if (pop_o && !head_i.write) begin
				rsp_valid_o <= 1'b1;
			end else if (rsp_ready_i) begin
				rsp_valid_o <= 1'b0;
			end
		end
	end

	// read data is captured when the read executes
	always_ff @(posedge clk48m) begin
		if (pop_o && !head_i.write) begin
			rsp_data_o <= bus_rsp_t'(rd_data);
		end
	end

	fsel_sequencer u_fsel_seq (
		.clk48m     (clk48m),
		.rst        (rst),
		.strobe_i   (fsel_strobe),
		.reload_i   (fsel_reload),
		.fsel_c_o   (fsel_c_o),
		.programn_o (programn_o)
	);

	// a stalled response must not change under the consumer
	a_rsp_hold: assert property (@(posedge clk48m) disable iff (rst)
		rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_data_o))
		else $error("response changed before it was accepted");

endmodule

/* soc_misc_top.sv */
/*
 * Top level of the misc bus slave. Connects the req/ack port, the request
 * queue and the register block; FIFO_DEPTH sizes the queue.
 */

`timescale 1ns/100ps

module soc_misc_top #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                                 clk48m,
	input  logic                                 rst,
	input  logic                                 req_i,
	input  soc_misc_pkg::bus_req_t               req_data_i,
	output logic                                 ack_o,
	output logic                                 rsp_valid_o,
	output soc_misc_pkg::bus_rsp_t               rsp_data_o,
	input  logic                                 rsp_ready_i,
	input  logic [soc_misc_pkg::BTN_W-1:0]       btn_i,
	input  logic [soc_misc_pkg::GENIO_W-1:0]     genio_in_i,
	output logic [soc_misc_pkg::LED_W-1:0]       led_o,
	output logic [soc_misc_pkg::GENIO_W-1:0]     genio_out_o,
	output logic [soc_misc_pkg::GENIO_W-1:0]     genio_oe_o,
	output logic                                 fsel_d_o,
	output logic                                 fsel_c_o,
	output logic                                 programn_o,
	output logic                                 bus_error_o
);
	import soc_misc_pkg::*;

	logic     fifo_full;
	logic     fifo_empty;
	logic     push;
	logic     pop;
	bus_req_t push_data;
	bus_req_t head;

	bus_port u_port (
		.clk48m      (clk48m),
		.rst         (rst),
		.req_i       (req_i),
		.req_data_i  (req_data_i),
		.ack_o       (ack_o),
		.full_i      (fifo_full),
		.push_o      (push),
		.push_data_o (push_data)
	);

	req_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.clk48m      (clk48m),
		.rst         (rst),
		.push_i      (push),
		.push_data_i (push_data),
		.full_o      (fifo_full),
		.pop_i       (pop),
		.empty_o     (fifo_empty),
		.head_o      (head)
	);

	misc_regs u_regs (
		.clk48m      (clk48m),
		.rst         (rst),
		.empty_i     (fifo_empty),
		.head_i      (head),
		.pop_o       (pop),
		.rsp_valid_o (rsp_valid_o),
		.rsp_data_o  (rsp_data_o),
		.rsp_ready_i (rsp_ready_i),
		.btn_i       (btn_i),
		.genio_in_i  (genio_in_i),
		.led_o       (led_o),
		.genio_out_o (genio_out_o),
		.genio_oe_o  (genio_oe_o),
		.fsel_d_o    (fsel_d_o),
		.fsel_c_o    (fsel_c_o),
		.programn_o  (programn_o),
		.bus_error_o (bus_error_o)
	);

endmodule

/* tb_soc_misc.sv */
/*
 * Testbench for the misc register bus slave. Reads vectors from a text file,
 * runs them through the req/ack port, scores responses and checks the pins.
 */

`timescale 1ns/100ps

module tb_soc_misc;
	import soc_misc_pkg::*;

	localparam int          FIFO_DEPTH     = 4;
	localparam int          ACK_WINDOW     = 8;
	localparam logic [3:0]  MISC_REGION    = 4'h2;
	localparam logic [23:0] FLASH_KEY      = 24'hD0F1A5;
	localparam logic [7:0]  BTN_VALUE      = 8'h5A;
	localparam logic [29:0] GENIO_IN_VALUE = 30'h1234_5678;

	typedef struct packed {
		logic [7:0]  op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [3:0]  strb;
		logic [31:0] rd_exp;
	} vector_t;

	// expected read data plus the pin state after all earlier writes
	typedef struct packed {
		logic [31:0] rdata;
		logic [15:0] led;
		logic [29:0] gout;
		logic [29:0] goe;
		logic        fsel_d;
	} rsp_expect_t;

	logic        clk48m      = 1'b0;
	logic        rst         = 1'b1;
	logic        req_i       = 1'b0;
	bus_req_t    req_data_i  = '0;
	logic        rsp_ready_i = 1'b0;
	logic [7:0]  btn_i       = BTN_VALUE;
	logic [29:0] genio_in_i  = GENIO_IN_VALUE;
	logic        ack_o;
	logic        rsp_valid_o;
	bus_rsp_t    rsp_data_o;
	logic [15:0] led_o;
	logic [29:0] genio_out_o;
	logic [29:0] genio_oe_o;
	logic        fsel_d_o;
	logic        fsel_c_o;
	logic        programn_o;
	logic        bus_error_o;

	vector_t     vectors[$];
	rsp_expect_t exp_q[$];
	bit          fsel_keys[$];
	integer      seed            = 32'h327a;
	int          cycles          = 0;
	int          cycle_limit     = 0;
	bit          hold_ready_low  = 1'b0;
	int          errors_seen     = 0;
	int          errors_expected = 0;
	int          fsel_writes     = 0;
	int          fsel_pulses     = 0;
	int          pulse_width     = 0;
	int          since_fall      = 3;
	bit          prog_expect_low = 1'b0;
	logic        fsel_c_prev     = 1'b0;
	logic        prog_prev       = 1'b1;
	logic [15:0] model_led       = '0;
	logic [29:0] model_gout      = '0;
	logic [29:0] model_goe       = '0;
	logic        model_fsel_d    = 1'b0;

	soc_misc_top #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) dut (
		.clk48m      (clk48m),
		.rst         (rst),
		.req_i       (req_i),
		.req_data_i  (req_data_i),
		.ack_o       (ack_o),
		.rsp_valid_o (rsp_valid_o),
		.rsp_data_o  (rsp_data_o),
		.rsp_ready_i (rsp_ready_i),
		.btn_i       (btn_i),
		.genio_in_i  (genio_in_i),
		.led_o       (led_o),
		.genio_out_o (genio_out_o),
		.genio_oe_o  (genio_oe_o),
		.fsel_d_o    (fsel_d_o),
		.fsel_c_o    (fsel_c_o),
		.programn_o  (programn_o),
		.bus_error_o (bus_error_o)
	);

	always #2 clk48m = ~clk48m;

	// ------------------------------------------------------------------------
	// failure reporting
	// ------------------------------------------------------------------------

	task automatic report_failure(input string text);
		$display("%s", text);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_equal(input logic [31:0] got, input logic [31:0] expected,
			input string what);
		if (got !== expected) begin
			report_failure($sformatf("CHECK FAILED at %0t: %s, got %h expected %h",
				$time, what, got, expected));
		end
	endtask

	// ------------------------------------------------------------------------
	// vector file and reference model
	// ------------------------------------------------------------------------

	task automatic load_vectors();
		int               fd;
		int               n;
		logic [8*128-1:0] line;
		logic [7:0]       op;
		logic [31:0]      addr;
		logic [31:0]      data;
		logic [3:0]       strb;
		logic [31:0]      rd_exp;
		vector_t          v;
		fd = $fopen("tb_soc_misc_input.txt", "r");
		if (fd == 0) begin
			report_failure("could not open the vector file tb_soc_misc_input.txt");
		end else begin
			line = '0;
			// comment lines never scan as five fields
			while ($fgets(line, fd) != 0) begin
				n = $sscanf(line, "%s %h %h %h %h", op, addr, data, strb, rd_exp);
				if (n == 5) begin
					if (op != "W" && op != "R" && op != "P") begin
						report_failure("vector file holds an unknown operation");
					end
					v = '{op, addr, data, strb, rd_exp};
					vectors.push_back(v);
				end
				line = '0;
			end
			$fclose(fd);
		end
	endtask

	// updates the model for a write and queues the expectation for a read
	task automatic prepare_request(input vector_t v, output bus_req_t r);
		rsp_expect_t e;
		r.write = (v.op == "W");
		r.addr  = v.addr;
		r.wdata = v.data;
		r.strb  = v.strb;
		if (v.addr[31:28] != MISC_REGION) begin
			errors_expected = errors_expected + 1;
		end else if (v.op == "W" && v.strb[0]) begin
			case (v.addr[6:2])
				5'd0:  model_led = v.data[15:0];
				5'd13: begin
					model_fsel_d = v.data[0];
					fsel_keys.push_back(v.data[31:8] == FLASH_KEY);
					fsel_writes = fsel_writes + 1;
				end
				5'd18: model_gout = v.data[29:0];
				5'd19: model_goe = v.data[29:0];
				5'd20: model_gout = model_gout | v.data[29:0];
				5'd21: model_gout = model_gout & ~v.data[29:0];
				default: ;
			endcase
		end
		if (v.op == "R") begin
			e = '{v.rd_exp, model_led, model_gout, model_goe, model_fsel_d};
			exp_q.push_back(e);
		end
	endtask

	// ------------------------------------------------------------------------
	// four-phase master
	// ------------------------------------------------------------------------

	task automatic raise_request(input bus_req_t r);
		@(posedge clk48m);
		#0.5;
		req_data_i = r;
		req_i      = 1'b1;
	endtask

	// a window of 0 waits until the global timeout
	task automatic wait_ack(input logic level, input int window, output bit seen);
		int waited;
		seen   = 1'b0;
		waited = 0;
		while (!seen && (window == 0 || waited < window)) begin
			@(negedge clk48m);
			waited = waited + 1;
			if (ack_o == level) begin
				seen = 1'b1;
			end
		end
	endtask

	task automatic drop_request();
		bit seen;
		@(posedge clk48m);
		#0.5;
		req_i = 1'b0;
		wait_ack(1'b0, 0, seen);
	endtask

	task automatic send_request(input bus_req_t r);
		bit seen;
		raise_request(r);
		wait_ack(1'b1, 0, seen);
		drop_request();
	endtask

	// reads with responses held back until the queue fills and ack stops
	task automatic run_stall_burst(input int first, input int count);
		bus_req_t r;
		bit       seen;
		bit       stalled;
		int       acked;
		if (first + count > vectors.size()) begin
			report_failure("stall burst runs past the end of the vector file");
		end
		while (exp_q.size() != 0) begin
			@(negedge clk48m);
		end
		hold_ready_low = 1'b1;
		stalled        = 1'b0;
		acked          = 0;
		for (int k = 0; k < count; k++) begin
			if (vectors[first + k].op != "R") begin
				report_failure("stall burst holds a vector that is not a read");
			end
			prepare_request(vectors[first + k], r);
			raise_request(r);
			wait_ack(1'b1, stalled ? 0 : ACK_WINDOW, seen);
			if (!seen) begin
				// one read executed and waiting plus FIFO_DEPTH reads queued
				check_equal(acked, FIFO_DEPTH + 1, "reads acknowledged before ack stopped");
				stalled        = 1'b1;
				hold_ready_low = 1'b0;
				wait_ack(1'b1, 0, seen);
			end
			drop_request();
			acked = acked + 1;
		end
		check_equal({31'b0, stalled}, 32'd1, "ack_o stalled while responses were held");
		hold_ready_low = 1'b0;
	endtask

	// ------------------------------------------------------------------------
	// response port, monitors and timeout
	// ------------------------------------------------------------------------

	always @(posedge clk48m) begin
		#0.5;
		if (rst || hold_ready_low) begin
			rsp_ready_i = 1'b0;
		end else begin
			rsp_ready_i = (($random(seed) & 32'd3) != 32'd0);
		end
	end

	task automatic check_response();
		rsp_expect_t e;
		if (exp_q.size() == 0) begin
			report_failure("a response arrived with no read outstanding");
		end
		e = exp_q.pop_front();
		check_equal(rsp_data_o.rdata, e.rdata, "read data");
		check_equal({16'b0, led_o}, {16'b0, e.led}, "led_o");
		check_equal({2'b0, genio_out_o}, {2'b0, e.gout}, "genio_out_o");
		check_equal({2'b0, genio_oe_o}, {2'b0, e.goe}, "genio_oe_o");
		check_equal({31'b0, fsel_d_o}, {31'b0, e.fsel_d}, "fsel_d_o");
	endtask

	task automatic track_flash_select();
		if (fsel_c_o && !fsel_c_prev) begin
			pulse_width = 1;
		end else if (fsel_c_o) begin
			pulse_width = pulse_width + 1;
		end
		if (!fsel_c_o && fsel_c_prev) begin
			check_equal(pulse_width, 3, "fsel_c_o pulse width");
			if (fsel_keys.size() == 0) begin
				report_failure("fsel_c_o pulsed without a flash-select write");
			end else if (fsel_keys.pop_front()) begin
				prog_expect_low = 1'b1;
			end
			fsel_pulses = fsel_pulses + 1;
			since_fall  = 0;
		end else if (since_fall < 3) begin
			since_fall = since_fall + 1;
			if (since_fall == 2) begin
				check_equal({31'b0, programn_o}, {31'b0, ~prog_expect_low},
					"programn_o two cycles after fsel_c_o fell");
			end
		end
		if (!programn_o && prog_prev && since_fall != 2) begin
			report_failure("programn_o fell at an unexpected time");
		end
		if (programn_o && !prog_prev) begin
			report_failure("programn_o rose again before reset");
		end
		fsel_c_prev = fsel_c_o;
		prog_prev   = programn_o;
	endtask

	// outputs are sampled at the falling edge between register updates
	always @(negedge clk48m) begin
		if (!rst) begin
			if (bus_error_o) begin
				errors_seen = errors_seen + 1;
			end
			if (rsp_valid_o && rsp_ready_i) begin
				check_response();
			end
			track_flash_select();
		end
	end

	always @(posedge clk48m) begin
		cycles = cycles + 1;
		if (cycle_limit != 0 && cycles > cycle_limit) begin
			report_failure($sformatf("timeout, no progress after %0d cycles", cycles));
		end
	end

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------

	initial begin
		int       i;
		int       burst;
		bus_req_t r;
		load_vectors();
		cycle_limit = 200 * vectors.size() + 500;
		repeat (4) @(posedge clk48m);
		#0.5;
		rst = 1'b0;
		@(negedge clk48m);
		check_equal({26'b0, ack_o, rsp_valid_o, bus_error_o, fsel_c_o, programn_o, fsel_d_o},
			32'h2, "control outputs after reset");
		check_equal({16'b0, led_o}, 32'd0, "led_o after reset");
		check_equal({2'b0, genio_out_o}, 32'd0, "genio_out_o after reset");
		check_equal({2'b0, genio_oe_o}, 32'd0, "genio_oe_o after reset");
		i = 0;
		while (i < vectors.size()) begin
			if (vectors[i].op == "P") begin
				burst = int'(vectors[i].data);
				run_stall_burst(i + 1, burst);
				i = i + 1 + burst;
			end else begin
				prepare_request(vectors[i], r);
				send_request(r);
				i = i + 1;
			end
		end
		while (exp_q.size() != 0) begin
			@(negedge clk48m);
		end
		while (fsel_pulses != fsel_writes || since_fall < 2) begin
			@(negedge clk48m);
		end
		@(negedge clk48m);
		check_equal({31'b0, programn_o}, {31'b0, ~prog_expect_low}, "programn_o at end of run");
		check_equal(errors_seen, errors_expected, "bus_error_o pulse count");
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

/* tb_soc_misc_input.txt */
# op addr data strb read_expect, all values hex
# ops W = write, R = read, P = hold responses low for the next <data> reads
W 20000000 CAFEBABE F 00000000
R 20000000 00000000 0 0000BABE
W 20000048 0ABCDEF0 F 00000000
W 2000004C 3FFF0000 F 00000000
R 20000048 00000000 0 0ABCDEF0
R 2000004C 00000000 0 3FFF0000
W 20000050 00000105 F 00000000
R 20000048 00000000 0 0ABCDFF5
W 20000054 0ABC0000 F 00000000
R 20000048 00000000 0 0000DFF5
W 20000050 FFFFFFFF 1 00000000
R 20000048 00000000 0 3FFFFFFF
W 20000054 30000003 F 00000000
R 20000048 00000000 0 0FFFFFFC
R 20000044 00000000 0 12345678
R 20000004 00000000 0 000000A5
R 20000008 00000000 0 00008000
R 20000014 00000000 0 00000000
R 30000000 00000000 0 DEADBEEF
R 00000008 00000000 0 DEADBEEF
W 10000000 12345678 F 00000000
W 20000000 00001111 E 00000000
R 20000000 00000000 0 0000BABE
W 20000034 00000001 F 00000000
R 20000034 00000000 0 00000001
R 20000008 00000000 0 00008000
R 20000004 00000000 0 000000A5
R 20000044 00000000 0 12345678
W 20000034 D0F1A500 F 00000000
R 20000034 00000000 0 00000000
P 00000000 00000007 0 00000000
R 20000000 00000000 0 0000BABE
R 20000008 00000000 0 00008000
R 20000004 00000000 0 000000A5
R F0000000 00000000 0 DEADBEEF
R 20000048 00000000 0 0FFFFFFC
R 2000004C 00000000 0 3FFF0000
R 20000034 00000000 0 00000000
R 20000044 00000000 0 12345678

/* soc_misc.f */
soc_misc_pkg.sv
fsel_sequencer.sv
bus_port.sv
req_fifo.sv
misc_regs.sv
soc_misc_top.sv
tb_soc_misc.sv

/* run_sim.sh */
#!/bin/sh
# build the misc bus slave testbench with Verilator and run it
# the run passes only if the pass message shows up in the output

cd "$(dirname "$0")" &&
verilator --binary --timing --assert \
	-f soc_misc.f \
	--top-module tb_soc_misc &&
./obj_dir/Vtb_soc_misc | tee /dev/stderr | grep -qF '*** TEST PASSED ***' &&
echo "run_sim: simulation passed" ||
{
	echo "run_sim: simulation failed"
	exit 1
}
